/* src/core_pkg.sv */
`default_nettype none

package core_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

	// outstanding request limit at the memory port
	localparam int MEM_CREDITS = 2;
	localparam int CREDIT_W = $clog2(MEM_CREDITS + 1);
	localparam int OWNER_PTR_W = $clog2(MEM_CREDITS);

	// buffered plus in-flight instructions in fetch
	localparam int FETCH_DEPTH = 2;
	localparam int FETCH_CNT_W = $clog2(FETCH_DEPTH + 1);
	localparam int FETCH_PTR_W = $clog2(FETCH_DEPTH);

	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;

	localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

	// one instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [REG_ADDR_W-1:0] rs2;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0] funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0] funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0] opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;
			logic [REG_ADDR_W-1:0] rs2;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
	} instr_u;

	typedef enum logic {
		FETCH,
		EXEC
	} owner_e;

endpackage

`default_nettype wire

/* src/mem_req_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface mem_req_if;
	logic req;
	logic [core_pkg::XLEN-1:0] addr;
	logic write;
	logic [core_pkg::XLEN-1:0] wdata;
	logic gnt;
	// one pulse per accepted request, in order
	logic rvalid;
	logic [core_pkg::XLEN-1:0] rdata;

	modport requester (
		output req,
		output addr,
		output write,
		output wdata,
		input gnt,
		input rvalid,
		input rdata
	);

	modport arbiter (
		input req,
		input addr,
		input write,
		input wdata,
		output gnt,
		output rvalid,
		output rdata
	);
endinterface

`default_nettype wire

/* src/fetch_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface fetch_if;
	logic valid;
	logic ready;
	logic [core_pkg::XLEN-1:0] pc;
	core_pkg::instr_u inst;

	modport source (
		output valid,
		output pc,
		output inst,
		input ready
	);

	modport sink (
		input valid,
		input pc,
		input inst,
		output ready
	);
endinterface

`default_nettype wire

/* src/regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module regfile (
	input wire clock,
	input wire reset,
	input wire [core_pkg::REG_ADDR_W-1:0] rs1_addr_i,
	input wire [core_pkg::REG_ADDR_W-1:0] rs2_addr_i,
	output logic [core_pkg::XLEN-1:0] rs1_data_o,
	output logic [core_pkg::XLEN-1:0] rs2_data_o,
	input wire wen_i,
	input wire [core_pkg::REG_ADDR_W-1:0] rd_addr_i,
	input wire [core_pkg::XLEN-1:0] rd_data_i
);
	// x0 has no storage
	logic [core_pkg::XLEN-1:0] regs_q [1:2**core_pkg::REG_ADDR_W-1];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < 2**core_pkg::REG_ADDR_W; i++)
				regs_q[i] <= '0;
		end else if (wen_i && rd_addr_i != '0) begin
			regs_q[rd_addr_i] <= rd_data_i;
		end
	end

	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];
endmodule

`default_nettype wire

/* src/fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
	input wire clock,
	input wire reset,
	mem_req_if.requester mem,
	fetch_if.source inst_out
);
	logic run_q;
	logic [core_pkg::XLEN-1:0] fetch_pc_q;
	logic [core_pkg::XLEN-1:0] resp_pc_q;
	logic [core_pkg::FETCH_CNT_W-1:0] pending_q;
	logic [core_pkg::FETCH_CNT_W-1:0] count_q;
	logic [core_pkg::FETCH_PTR_W-1:0] wr_ptr_q;
	logic [core_pkg::FETCH_PTR_W-1:0] rd_ptr_q;
	logic [core_pkg::XLEN-1:0] buf_pc_q [core_pkg::FETCH_DEPTH];
	core_pkg::instr_u buf_inst_q [core_pkg::FETCH_DEPTH];
	logic issue;
	logic pop;

	// no branches, so always prefetch the next sequential word
	assign mem.req = run_q && ((count_q + pending_q) < core_pkg::FETCH_DEPTH);
	assign mem.addr = fetch_pc_q;
	assign mem.write = 1'b0;
	assign mem.wdata = '0;

	assign issue = mem.req & mem.gnt;
	assign pop = inst_out.valid & inst_out.ready;

	assign inst_out.valid = count_q != '0;
	assign inst_out.pc = buf_pc_q[rd_ptr_q];
	assign inst_out.inst = buf_inst_q[rd_ptr_q];

	always_ff @(posedge clock) begin
		if (reset) begin
			run_q <= 1'b0;
			fetch_pc_q <= core_pkg::RESET_PC;
			resp_pc_q <= core_pkg::RESET_PC;
			pending_q <= '0;
			count_q <= '0;
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			// first request one cycle after reset
			run_q <= 1'b1;
			if (issue)
				fetch_pc_q <= fetch_pc_q + 32'd4;
			if (mem.rvalid) begin
				resp_pc_q <= resp_pc_q + 32'd4;
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({issue, mem.rvalid})
				2'b10: pending_q <= pending_q + 1'b1;
				2'b01: pending_q <= pending_q - 1'b1;
				default: ;
			endcase
			case ({mem.rvalid, pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: ;
			endcase
		end
	end

	// responses arrive in order, so the pc is just counted
	always_ff @(posedge clock) begin
		if (mem.rvalid) begin
			buf_pc_q[wr_ptr_q] <= resp_pc_q;
			buf_inst_q[wr_ptr_q] <= mem.rdata;
		end
	end
endmodule

`default_nettype wire

/* src/exec_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
	input wire clock,
	input wire reset,
	fetch_if.sink inst_in,
	mem_req_if.requester mem,
	output logic commit_valid_o,
	output logic [core_pkg::XLEN-1:0] commit_pc_o,
	output logic [core_pkg::REG_ADDR_W-1:0] commit_rd_o,
	output logic [core_pkg::XLEN-1:0] commit_data_o
);
	core_pkg::instr_u inst;
	logic [6:0] opcode;
	logic [core_pkg::XLEN-1:0] rs1_data;
	logic [core_pkg::XLEN-1:0] rs2_data;
	logic [core_pkg::XLEN-1:0] imm_i;
	logic [core_pkg::XLEN-1:0] imm_s;
	logic [core_pkg::XLEN-1:0] imm_u;
	logic [core_pkg::XLEN-1:0] alu_result;
	logic alu_op;
	logic is_load;
	logic is_store;
	logic mem_op;
	logic accept;
	logic mem_done;
	logic load_done;
	logic rf_wen;
	logic [core_pkg::REG_ADDR_W-1:0] rf_waddr;
	logic [core_pkg::XLEN-1:0] rf_wdata;
	logic busy_q;
	logic granted_q;
	logic write_q;
	logic [core_pkg::XLEN-1:0] addr_q;
	logic [core_pkg::XLEN-1:0] wdata_q;
	logic [core_pkg::XLEN-1:0] pc_q;
	logic [core_pkg::REG_ADDR_W-1:0] rd_q;

	assign inst = inst_in.inst;
	assign opcode = inst.r.opcode;
	assign imm_i = {{(core_pkg::XLEN-12){inst.i.imm[11]}}, inst.i.imm};
	assign imm_s = {{(core_pkg::XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
	assign imm_u = {inst.i.imm, inst.i.rs1, inst.i.funct3, 12'b0};

	always_comb begin
		alu_op = 1'b1;
		case (opcode)
			core_pkg::OPC_OP: begin
				if (inst.r.funct7 == core_pkg::FUNCT7_SUB)
					alu_result = rs1_data - rs2_data;
				else
					alu_result = rs1_data + rs2_data;
			end
			core_pkg::OPC_OP_IMM: alu_result = rs1_data + imm_i;
			core_pkg::OPC_LUI: alu_result = imm_u;
			default: begin
				alu_op = 1'b0;
				alu_result = '0;
			end
		endcase
	end

	assign is_load = opcode == core_pkg::OPC_LOAD;
	assign is_store = opcode == core_pkg::OPC_STORE;
	assign mem_op = is_load | is_store;

	// one instruction at a time, ready drops only for loads and stores
	assign inst_in.ready = ~busy_q;
	assign accept = inst_in.valid & ~busy_q;
	assign mem_done = busy_q & granted_q & mem.rvalid;
	assign load_done = mem_done & ~write_q;

	assign mem.req = busy_q & ~granted_q;
	assign mem.addr = addr_q;
	assign mem.write = write_q;
	assign mem.wdata = wdata_q;

	assign rf_wen = load_done | (accept & alu_op);
	assign rf_waddr = load_done ? rd_q : inst.r.rd;
	assign rf_wdata = load_done ? mem.rdata : alu_result;

	regfile regfile_i (
		.clock (clock),
		.reset (reset),
		.rs1_addr_i (inst.r.rs1),
		.rs2_addr_i (inst.r.rs2),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.wen_i (rf_wen),
		.rd_addr_i (rf_waddr),
		.rd_data_i (rf_wdata)
	);

	always_ff @(posedge clock) begin
		if (reset) begin
			busy_q <= 1'b0;
			granted_q <= 1'b0;
			commit_valid_o <= 1'b0;
		end else begin
			commit_valid_o <= (accept & ~mem_op) | mem_done;
			if (accept & mem_op) begin
				busy_q <= 1'b1;
				granted_q <= 1'b0;
			end else if (mem_done) begin
				busy_q <= 1'b0;
			end
			if (mem.req & mem.gnt)
				granted_q <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (accept & mem_op) begin
			pc_q <= inst_in.pc;
			// stores retire with rd 0
			rd_q <= is_load ? inst.r.rd : '0;
			write_q <= is_store;
			addr_q <= rs1_data + (is_store ? imm_s : imm_i);
			wdata_q <= rs2_data;
		end
		if (accept & ~mem_op) begin
			commit_pc_o <= inst_in.pc;
			commit_rd_o <= alu_op ? inst.r.rd : '0;
			commit_data_o <= (alu_op && inst.r.rd != '0) ? alu_result : '0;
		end else if (mem_done) begin
			commit_pc_o <= pc_q;
			commit_rd_o <= rd_q;
			commit_data_o <= (rd_q != '0) ? mem.rdata : '0;
		end
	end
endmodule

`default_nettype wire

/* src/mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
	input wire clock,
	input wire reset,
	mem_req_if.arbiter fetch_req,
	mem_req_if.arbiter exec_req,
	output logic mem_req_valid_o,
	output logic [core_pkg::XLEN-1:0] mem_req_addr_o,
	output logic mem_req_write_o,
	output logic [core_pkg::XLEN-1:0] mem_req_wdata_o,
	input wire mem_credit_i,
	input wire mem_resp_valid_i,
	input wire [core_pkg::XLEN-1:0] mem_resp_rdata_i
);
	logic [core_pkg::CREDIT_W-1:0] credits_q;
	logic has_credit;
	logic send;
	core_pkg::owner_e owner_q [core_pkg::MEM_CREDITS];
	logic [core_pkg::OWNER_PTR_W-1:0] push_ptr_q;
	logic [core_pkg::OWNER_PTR_W-1:0] pop_ptr_q;
	core_pkg::owner_e head;

	assign has_credit = credits_q != '0;

	// execute wins over fetch
	assign exec_req.gnt = exec_req.req & has_credit;
	assign fetch_req.gnt = fetch_req.req & has_credit & ~exec_req.req;
	assign send = exec_req.gnt | fetch_req.gnt;

	assign mem_req_valid_o = send;
	assign mem_req_addr_o = exec_req.req ? exec_req.addr : fetch_req.addr;
	assign mem_req_write_o = exec_req.req ? exec_req.write : fetch_req.write;
	assign mem_req_wdata_o = exec_req.req ? exec_req.wdata : fetch_req.wdata;

	// responses come back in request order
	assign head = owner_q[pop_ptr_q];
	assign exec_req.rvalid = mem_resp_valid_i & (head == core_pkg::EXEC);
	assign fetch_req.rvalid = mem_resp_valid_i & (head == core_pkg::FETCH);
	assign exec_req.rdata = mem_resp_rdata_i;
	assign fetch_req.rdata = mem_resp_rdata_i;

	always_ff @(posedge clock) begin
		if (reset) begin
			credits_q <= core_pkg::CREDIT_W'(core_pkg::MEM_CREDITS);
			push_ptr_q <= '0;
			pop_ptr_q <= '0;
		end else begin
			case ({send, mem_credit_i})
				2'b10: credits_q <= credits_q - 1'b1;
				2'b01: credits_q <= credits_q + 1'b1;
				default: ;
			endcase
			if (send)
				push_ptr_q <= push_ptr_q + 1'b1;
			if (mem_resp_valid_i)
				pop_ptr_q <= pop_ptr_q + 1'b1;
		end
	end

	// at most MEM_CREDITS requests await a response
	always_ff @(posedge clock) begin
		if (send)
			owner_q[push_ptr_q] <= exec_req.req ? core_pkg::EXEC : core_pkg::FETCH;
	end
endmodule

`default_nettype wire

/* src/rv_core_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_top (
	input wire clock,
	input wire reset,
	output wire mem_req_valid_o,
	output wire [core_pkg::XLEN-1:0] mem_req_addr_o,
	output wire mem_req_write_o,
	output wire [core_pkg::XLEN-1:0] mem_req_wdata_o,
	input wire mem_credit_i,
	input wire mem_resp_valid_i,
	input wire [core_pkg::XLEN-1:0] mem_resp_rdata_i,
	output wire commit_valid_o,
	output wire [core_pkg::XLEN-1:0] commit_pc_o,
	output wire [core_pkg::REG_ADDR_W-1:0] commit_rd_o,
	output wire [core_pkg::XLEN-1:0] commit_data_o
);
	fetch_if fetch_bus ();
	mem_req_if fetch_mem ();
	mem_req_if exec_mem ();

	fetch_unit fetch_unit_i (
		.clock (clock),
		.reset (reset),
		.mem (fetch_mem),
		.inst_out (fetch_bus)
	);

	exec_unit exec_unit_i (
		.clock (clock),
		.reset (reset),
		.inst_in (fetch_bus),
		.mem (exec_mem),
		.commit_valid_o (commit_valid_o),
		.commit_pc_o (commit_pc_o),
		.commit_rd_o (commit_rd_o),
		.commit_data_o (commit_data_o)
	);

	// single memory port shared by both units
	mem_arbiter mem_arbiter_i (
		.clock (clock),
		.reset (reset),
		.fetch_req (fetch_mem),
		.exec_req (exec_mem),
		.mem_req_valid_o (mem_req_valid_o),
		.mem_req_addr_o (mem_req_addr_o),
		.mem_req_write_o (mem_req_write_o),
		.mem_req_wdata_o (mem_req_wdata_o),
		.mem_credit_i (mem_credit_i),
		.mem_resp_valid_i (mem_resp_valid_i),
		.mem_resp_rdata_i (mem_resp_rdata_i)
	);
endmodule

`default_nettype wire

/* test/rv_core_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_properties (
	input wire clock,
	input wire reset,
	input wire req_valid_i,
	input wire resp_valid_i,
	input wire [core_pkg::CREDIT_W-1:0] credits_i,
	input var core_pkg::owner_e head_i
);
	// no request may leave without a credit
	no_req_without_credit: assert property (@(posedge clock) disable iff (reset)
		(credits_i == '0) |-> !req_valid_i)
		else $error("memory request sent with zero credits");

	credit_bound: assert property (@(posedge clock) disable iff (reset)
		credits_i <= core_pkg::MEM_CREDITS)
		else $error("credit count above the memory limit");

	quiet_after_reset: assert property (@(posedge clock)
		reset |=> !req_valid_i)
		else $error("memory request in the cycle after reset");

	// every response needs a recorded owner
	owner_known: assert property (@(posedge clock) disable iff (reset)
		resp_valid_i |-> !$isunknown(head_i))
		else $error("response arrived with no known owner");
endmodule

`default_nettype wire

/* test/rv_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;
	localparam int MEM_WORDS = 256;
	localparam int MAX_ROWS = 32;
	localparam int COMMIT_TIMEOUT = 40;

	logic clock;
	logic reset;
	logic mem_req_valid_o;
	logic [31:0] mem_req_addr_o;
	logic mem_req_write_o;
	logic [31:0] mem_req_wdata_o;
	logic mem_credit_i;
	logic mem_resp_valid_i;
	logic [31:0] mem_resp_rdata_i;
	logic commit_valid_o;
	logic [31:0] commit_pc_o;
	logic [4:0] commit_rd_o;
	logic [31:0] commit_data_o;

	logic [31:0] mem [MEM_WORDS];
	logic [31:0] prog_inst [MAX_ROWS];
	logic [4:0] exp_rd [MAX_ROWS];
	logic [31:0] exp_data [MAX_ROWS];
	int num_rows;
	int errors;
	int checks;
	int outstanding;
	int cycle_cnt;
	logic [31:0] lfsr;
	int due_q [$];
	logic [31:0] data_q [$];

	rv_core_top dut_i (
		.clock (clock),
		.reset (reset),
		.mem_req_valid_o (mem_req_valid_o),
		.mem_req_addr_o (mem_req_addr_o),
		.mem_req_write_o (mem_req_write_o),
		.mem_req_wdata_o (mem_req_wdata_o),
		.mem_credit_i (mem_credit_i),
		.mem_resp_valid_i (mem_resp_valid_i),
		.mem_resp_rdata_i (mem_resp_rdata_i),
		.commit_valid_o (commit_valid_o),
		.commit_pc_o (commit_pc_o),
		.commit_rd_o (commit_rd_o),
		.commit_data_o (commit_data_o)
	);

	bind mem_arbiter rv_core_properties props_i (
		.clock (clock),
		.reset (reset),
		.req_valid_i (mem_req_valid_o),
		.resp_valid_i (mem_resp_valid_i),
		.credits_i (credits_q),
		.head_i (head)
	);

	always #10 clock = ~clock;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic fb;
		fb = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], fb};
	endfunction

	function automatic logic [31:0] op_add(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2);
		return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] op_sub(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2);
		return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] op_addi(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] op_lui(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] op_lw(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, 7'b0000011};
	endfunction

	function automatic logic [31:0] op_sw(input logic [4:0] rs2, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	task automatic add_row(input logic [31:0] inst, input logic [4:0] rd,
			input logic [31:0] data);
		prog_inst[num_rows] = inst;
		exp_rd[num_rows] = rd;
		exp_data[num_rows] = data;
		num_rows++;
	endtask

	task automatic compare_word(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_quiet();
		compare_word("commit_valid_o in reset", {31'b0, commit_valid_o}, 32'd0);
		compare_word("mem_req_valid_o in reset", {31'b0, mem_req_valid_o}, 32'd0);
	endtask

	task automatic wait_commit(output bit seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < COMMIT_TIMEOUT) begin
			@(negedge clock);
			if (commit_valid_o === 1'b1)
				seen = 1'b1;
			n++;
		end
	endtask

	// x7 points at 0x204 in the data region
	task automatic build_program();
		num_rows = 0;
		add_row(op_addi(1, 0, 5), 1, 32'h0000_0005);
		add_row(op_addi(2, 0, -3), 2, 32'hffff_fffd);
		add_row(op_add(3, 1, 2), 3, 32'h0000_0002);
		add_row(op_sub(4, 1, 2), 4, 32'h0000_0008);
		add_row(op_lui(5, 20'h80000), 5, 32'h8000_0000);
		add_row(op_sub(6, 5, 1), 6, 32'h7fff_fffb);
		add_row(op_addi(7, 0, 12'h204), 7, 32'h0000_0204);
		add_row(op_lui(8, 20'h12345), 8, 32'h1234_5000);
		add_row(op_addi(8, 8, 12'h678), 8, 32'h1234_5678);
		add_row(op_sw(8, 7, 4), 0, 32'h0);
		add_row(op_lw(9, 7, 4), 9, 32'h1234_5678);
		add_row(op_sw(6, 7, -4), 0, 32'h0);
		add_row(op_lw(10, 7, -4), 10, 32'h7fff_fffb);
		add_row(op_addi(0, 1, 7), 0, 32'h0);
		add_row(op_add(11, 0, 1), 11, 32'h0000_0005);
		// opcode 7f with rd 13 is outside the subset
		add_row(32'h0000_06ff, 0, 32'h0);
		add_row(op_sw(4, 7, 8), 0, 32'h0);
		add_row(op_lw(13, 7, 8), 13, 32'h0000_0008);
		add_row(op_add(14, 13, 9), 14, 32'h1234_5680);
		add_row(op_lw(0, 7, 4), 0, 32'h0);
		add_row(op_add(15, 0, 0), 15, 32'h0);
	endtask

	// memory model, one response per cycle in request order
	always @(negedge clock) begin : mem_model
		int idx;
		logic [1:0] delay;
		logic [31:0] rdata;
		cycle_cnt++;
		mem_resp_valid_i = 1'b0;
		mem_credit_i = 1'b0;
		mem_resp_rdata_i = '0;
		if (reset) begin
			outstanding = 0;
			due_q.delete();
			data_q.delete();
		end else begin
			if (mem_req_valid_o === 1'b1) begin
				outstanding++;
				if (outstanding > core_pkg::MEM_CREDITS) begin
					errors++;
					$display("[FAIL] %0t: %0d requests outstanding, limit %0d", $time,
						outstanding, core_pkg::MEM_CREDITS);
				end
				idx = int'(mem_req_addr_o[9:2]);
				rdata = '0;
				if (mem_req_write_o)
					mem[idx] = mem_req_wdata_o;
				else
					rdata = mem[idx];
				lfsr = lfsr_next(lfsr);
				delay[0] = lfsr[0];
				lfsr = lfsr_next(lfsr);
				delay[1] = lfsr[0];
				due_q.push_back(cycle_cnt + 1 + int'(delay));
				data_q.push_back(rdata);
			end
			if (due_q.size() > 0 && due_q[0] <= cycle_cnt) begin
				mem_resp_valid_i = 1'b1;
				mem_credit_i = 1'b1;
				mem_resp_rdata_i = data_q[0];
				void'(due_q.pop_front());
				void'(data_q.pop_front());
				outstanding--;
			end
		end
	end

	initial begin
		int row;
		bit seen;
		bit timed_out;
		clock = 1'b0;
		reset = 1'b1;
		mem_credit_i = 1'b0;
		mem_resp_valid_i = 1'b0;
		mem_resp_rdata_i = '0;
		errors = 0;
		checks = 0;
		outstanding = 0;
		cycle_cnt = 0;
		lfsr = 32'h148c715f;
		timed_out = 1'b0;
		// unsupported opcode in every word, index in the upper bits
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = {i[24:0], 7'h7f};
		build_program();
		for (int i = 0; i < num_rows; i++)
			mem[i] = prog_inst[i];

		repeat (2) begin
			@(negedge clock);
			check_quiet();
		end
		reset = 1'b0;
		@(negedge clock);
		compare_word("commit_valid_o after reset", {31'b0, commit_valid_o}, 32'd0);

		for (row = 0; row < num_rows && !timed_out; row++) begin
			wait_commit(seen);
			if (!seen) begin
				errors++;
				timed_out = 1'b1;
				$display("timeout: instruction %0d did not commit within %0d cycles",
					row, COMMIT_TIMEOUT);
			end else begin
				compare_word($sformatf("row %0d commit pc", row), commit_pc_o,
					32'(row * 4));
				compare_word($sformatf("row %0d commit rd", row), {27'b0, commit_rd_o},
					{27'b0, exp_rd[row]});
				compare_word($sformatf("row %0d commit data", row), commit_data_o,
					exp_data[row]);
			end
		end

		// stored words still in the data region
		compare_word("mem[0x200]", mem[128], 32'h7fff_fffb);
		compare_word("mem[0x208]", mem[130], 32'h1234_5678);
		compare_word("mem[0x20c]", mem[131], 32'h0000_0008);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end
endmodule

`default_nettype wire

/* project.f */
src/core_pkg.sv
src/mem_req_if.sv
src/fetch_if.sv
src/regfile.sv
src/fetch_unit.sv
src/exec_unit.sv
src/mem_arbiter.sv
src/rv_core_top.sv
test/rv_core_properties.sv
test/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - src/core_pkg.sv
  - src/mem_req_if.sv
  - src/fetch_if.sv
  - src/regfile.sv
  - src/fetch_unit.sv
  - src/exec_unit.sv
  - src/mem_arbiter.sv
  - src/rv_core_top.sv
  - target: test
    files:
      - test/rv_core_properties.sv
      - test/rv_core_tb.sv
